// File: verilog/cpu_cfg_pkg.sv
// core configuration
package cpu_cfg_pkg;

  // datapath widths
  localparam int PC_WD        = 64;
  localparam int INST_WD      = 32;
  localparam int SRAM_DATA_WD = 64;

  // instruction memory geometry, one entry per 64-bit word
  localparam int IMEM_DEPTH   = 256;
  localparam int SRAM_ADDR_WD = $clog2(IMEM_DEPTH);

  // vectors with a meaning of their own
  typedef logic [PC_WD-1:0]        pc_t;
  typedef logic [INST_WD-1:0]      inst_t;
  typedef logic [SRAM_ADDR_WD-1:0] sram_addr_t;
  typedef logic [SRAM_DATA_WD-1:0] sram_data_t;

  // first fetched instruction
  localparam pc_t BOOT_PC     = 64'h8000_0000;

  // fs_pc sits one slot below boot in reset
  // so the first sequential nextpc lands on BOOT_PC
  localparam pc_t PC_RESETVAL = BOOT_PC - 64'd4;

endpackage

// File: verilog/rv_isa_pkg.sv
// rv64 decode fields
package rv_isa_pkg;

  // major opcode field, inst[6:0]
  localparam int OPCODE_LO = 0;
  localparam int OPCODE_HI = 6;

  // opcode field vector
  typedef logic [OPCODE_HI-OPCODE_LO:0] opcode_t;

  // jump and link, J-type encoding
  // imm[20|10:1|11|19:12] sits in inst[31:12]
  // rd in inst[11:7], unused by this front end
  localparam opcode_t OPCODE_JAL = 7'b110_1111;

endpackage

// File: verilog/inst_sram.sv
// instruction sram
`timescale 1ns/10ps

module inst_sram (
  input  logic                    i_clk,
  // loader write port
  input  logic                    i_we,
  input  cpu_cfg_pkg::sram_addr_t i_waddr,
  input  cpu_cfg_pkg::sram_data_t i_wdata,
  // fetch read port
  input  logic                    i_ren,
  input  cpu_cfg_pkg::sram_addr_t i_raddr,
  output cpu_cfg_pkg::sram_data_t o_rdata
);

  import cpu_cfg_pkg::*;

  // storage, one 64-bit word holds two instructions
  sram_data_t mem [IMEM_DEPTH];
  sram_data_t rdata_q;

  // loader port, active even while the core sits in reset
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // registered read
  // output only moves on a request, so a stalled fetch
  // keeps seeing the word it asked for
  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      rdata_q <= mem[i_raddr];
    end
  end

  assign o_rdata = rdata_q;

endmodule

// File: verilog/if_stage.sv
// instruction fetch stage
`timescale 1ns/10ps

module if_stage (
  input  logic                    i_clk,
  input  logic                    i_rst,
  // from decode register
  input  logic                    i_ds_allowin,
  // redirect from decode
  input  logic                    i_br_taken,
  input  cpu_cfg_pkg::pc_t        i_br_target,
  // to decode register
  output logic                    o_fs_valid,
  output cpu_cfg_pkg::pc_t        o_fs_pc,
  output cpu_cfg_pkg::inst_t      o_fs_inst,
  // instruction sram read request
  output logic                    o_inst_sram_ren,
  output cpu_cfg_pkg::sram_addr_t o_inst_sram_addr,
  input  cpu_cfg_pkg::sram_data_t i_inst_sram_rdata
);

  import cpu_cfg_pkg::*;

  // pre-fetch stage
  logic to_fs_valid;
  pc_t  seq_pc;
  pc_t  nextpc;

  // fetch stage
  logic fs_valid;
  logic fs_allowin;
  pc_t  fs_pc;

  // pre-fetch always has a request ready once out of reset
  assign to_fs_valid = ~i_rst;

  // fetch finishes in one cycle, so ready_go is tied high
  // accept when empty, or when decode takes the current one
  assign fs_allowin = ~fs_valid | i_ds_allowin;

  // next pc select
  // redirect wins; the instruction already in fetch is not
  // squashed and goes on as the delay slot
  assign seq_pc = fs_pc + 64'd4;
  assign nextpc = i_br_taken ? i_br_target : seq_pc;

  // fetch valid bit
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  // pc register
  // resets one slot below boot address
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_pc <= PC_RESETVAL;
    end else if (to_fs_valid && fs_allowin) begin
      fs_pc <= nextpc;
    end
  end

  // read the word for nextpc in the same cycle it is chosen
  // data returns as fs_pc moves to nextpc
  assign o_inst_sram_ren  = to_fs_valid & fs_allowin;
  // word index is pc[10:3]
  assign o_inst_sram_addr = nextpc[SRAM_ADDR_WD+2:3];

  // half select by pc[2]
  // pc[2] clear takes the upper half of the word
  assign o_fs_inst = fs_pc[2] ? i_inst_sram_rdata[INST_WD-1:0]
                              : i_inst_sram_rdata[SRAM_DATA_WD-1:INST_WD];

  // to decode
  assign o_fs_valid = fs_valid;
  assign o_fs_pc    = fs_pc;

endmodule

// File: verilog/ds_pipe_reg.sv
// fetch to decode register
`timescale 1ns/10ps

module ds_pipe_reg (
  input  logic               i_clk,
  input  logic               i_rst,
  // from fetch
  input  logic               i_fs_valid,
  input  cpu_cfg_pkg::pc_t   i_fs_pc,
  input  cpu_cfg_pkg::inst_t i_fs_inst,
  // back-pressure from execute
  input  logic               i_es_allowin,
  output logic               o_ds_allowin,
  // decode stage contents
  output logic               o_ds_valid,
  output cpu_cfg_pkg::pc_t   o_ds_pc,
  output cpu_cfg_pkg::inst_t o_ds_inst
);

  import cpu_cfg_pkg::*;

  logic  ds_valid;
  logic  ds_allowin;
  pc_t   ds_pc;
  inst_t ds_inst;

  // decode's own work fits in one cycle
  // so it frees up whenever execute takes the entry
  assign ds_allowin = ~ds_valid | i_es_allowin;

  // valid bit, cleared by reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  // payload only loads with a real instruction
  // holds while execute stalls
  always_ff @(posedge i_clk) begin
    if (i_fs_valid && ds_allowin) begin
      ds_pc   <= i_fs_pc;
      ds_inst <= i_fs_inst;
    end
  end

  assign o_ds_allowin = ds_allowin;
  assign o_ds_valid   = ds_valid;
  assign o_ds_pc      = ds_pc;
  assign o_ds_inst    = ds_inst;

endmodule

// File: verilog/id_branch_unit.sv
// decode jal redirect
`timescale 1ns/10ps

module id_branch_unit (
  // decode stage contents
  input  logic               i_ds_valid,
  input  cpu_cfg_pkg::pc_t   i_ds_pc,
  input  cpu_cfg_pkg::inst_t i_ds_inst,
  // departure qualifier
  input  logic               i_es_allowin,
  // redirect to fetch
  output logic               o_br_taken,
  output cpu_cfg_pkg::pc_t   o_br_target,
  // decode flag
  output logic               o_is_jal
);

  import cpu_cfg_pkg::*;
  import rv_isa_pkg::*;

  opcode_t     opcode;
  logic        is_jal;
  // J-type immediate, 21 bits with bit 0 always zero
  logic [20:0] j_imm;
  pc_t         j_offset;
  pc_t         jal_target;

  // opcode field
  assign opcode = i_ds_inst[OPCODE_HI:OPCODE_LO];

  // only a live decode entry counts
  assign is_jal = i_ds_valid & (opcode == OPCODE_JAL);

  // unscramble imm[20|10:1|11|19:12]
  assign j_imm = {
    i_ds_inst[31],
    i_ds_inst[19:12],
    i_ds_inst[20],
    i_ds_inst[30:21],
    1'b0
  };

  // sign extend up to pc width
  assign j_offset = {{(PC_WD-21){j_imm[20]}}, j_imm};

  // pc relative target
  assign jal_target = i_ds_pc + j_offset;

  // redirect fires only as the jal leaves decode
  // a stalled jal waits here and fires once on the way out
  assign o_br_taken  = is_jal & i_es_allowin;
  assign o_br_target = jal_target;

  // jal marker for later stages
  assign o_is_jal = is_jal;

endmodule

// File: verilog/fetch_top.sv
// fetch and decode front end
`timescale 1ns/10ps

module fetch_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  // instruction memory loader
  input  logic                    i_imem_we,
  input  cpu_cfg_pkg::sram_addr_t i_imem_waddr,
  input  cpu_cfg_pkg::sram_data_t i_imem_wdata,
  // back-pressure from execute
  input  logic                    i_es_allowin,
  // decode stage outputs
  output logic                    o_ds_valid,
  output cpu_cfg_pkg::pc_t        o_ds_pc,
  output cpu_cfg_pkg::inst_t      o_ds_inst,
  output logic                    o_ds_is_jal
);

  import cpu_cfg_pkg::*;

  // fetch to sram
  logic       inst_sram_ren;
  sram_addr_t inst_sram_addr;
  sram_data_t inst_sram_rdata;

  // fetch to decode register
  logic       fs_valid;
  pc_t        fs_pc;
  inst_t      fs_inst;
  logic       ds_allowin;

  // decode register to branch unit
  logic       ds_valid;
  pc_t        ds_pc;
  inst_t      ds_inst;

  // redirect back to fetch
  logic       br_taken;
  pc_t        br_target;

  // instruction memory
  // write side belongs to the loader
  inst_sram u_inst_sram (
    .i_clk   (i_clk),
    .i_we    (i_imem_we),
    .i_waddr (i_imem_waddr),
    .i_wdata (i_imem_wdata),
    .i_ren   (inst_sram_ren),
    .i_raddr (inst_sram_addr),
    .o_rdata (inst_sram_rdata)
  );

  // pc and fetch
  if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_ds_allowin      (ds_allowin),
    .i_br_taken        (br_taken),
    .i_br_target       (br_target),
    .o_fs_valid        (fs_valid),
    .o_fs_pc           (fs_pc),
    .o_fs_inst         (fs_inst),
    .o_inst_sram_ren   (inst_sram_ren),
    .o_inst_sram_addr  (inst_sram_addr),
    .i_inst_sram_rdata (inst_sram_rdata)
  );

  // decode stage register
  ds_pipe_reg u_ds_pipe_reg (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fs_valid   (fs_valid),
    .i_fs_pc      (fs_pc),
    .i_fs_inst    (fs_inst),
    .i_es_allowin (i_es_allowin),
    .o_ds_allowin (ds_allowin),
    .o_ds_valid   (ds_valid),
    .o_ds_pc      (ds_pc),
    .o_ds_inst    (ds_inst)
  );

  // jal resolved in decode
  id_branch_unit u_id_branch_unit (
    .i_ds_valid   (ds_valid),
    .i_ds_pc      (ds_pc),
    .i_ds_inst    (ds_inst),
    .i_es_allowin (i_es_allowin),
    .o_br_taken   (br_taken),
    .o_br_target  (br_target),
    .o_is_jal     (o_ds_is_jal)
  );

  // decode contents out to execute
  assign o_ds_valid = ds_valid;
  assign o_ds_pc    = ds_pc;
  assign o_ds_inst  = ds_inst;

endmodule

// File: testbench/tb_fetch_table.svh
// front end test programs
`ifndef TB_FETCH_TABLE_SVH
`define TB_FETCH_TABLE_SVH

localparam int NUM_ROWS  = 4;
localparam int ROW_WORDS = 4;

// program words, one row per test
// word k holds pc BOOT_PC+8k in [63:32] and BOOT_PC+8k+4 in [31:0]
sram_data_t prog_tab [NUM_ROWS][ROW_WORDS];
// percent of cycles with execute stalled
int         stall_pct_tab [NUM_ROWS];
// departures checked per row
int         n_dep_tab [NUM_ROWS];

task automatic fill_table();
  // row 0, straight line addi x1..x8, no stalls
  prog_tab[0][0] = 64'h0010_0093_0020_0113;
  prog_tab[0][1] = 64'h0030_0193_0040_0213;
  prog_tab[0][2] = 64'h0050_0293_0060_0313;
  prog_tab[0][3] = 64'h0070_0393_0080_0413;
  stall_pct_tab[0] = 0;
  n_dep_tab[0]     = 8;
  // row 1, jal ra,+12 at 0x04 and jal x0,-16 at 0x14
  // loop 0x04 .. 0x18, no stalls
  prog_tab[1][0] = 64'h00a0_0513_00c0_00ef;
  prog_tab[1][1] = 64'h00b0_0593_00c0_0613;
  prog_tab[1][2] = 64'h00d0_0693_ff1f_f06f;
  prog_tab[1][3] = 64'h00e0_0713_00f0_0793;
  stall_pct_tab[1] = 0;
  n_dep_tab[1]     = 12;
  // row 2, same jumps, new fillers, heavy back-pressure
  // jals sit stalled in decode for several cycles
  prog_tab[2][0] = 64'h0010_0813_00c0_00ef;
  prog_tab[2][1] = 64'h0020_0893_0030_0913;
  prog_tab[2][2] = 64'h0040_0993_ff1f_f06f;
  prog_tab[2][3] = 64'h0050_0a13_0060_0a93;
  stall_pct_tab[2] = 70;
  n_dep_tab[2]     = 20;
  // row 3, jal x0,+16 at 0x08 then jal x0,-8 loop at 0x18
  prog_tab[3][0] = 64'h0ff0_0b13_0fe0_0b93;
  prog_tab[3][1] = 64'h0100_006f_0fd0_0c13;
  prog_tab[3][2] = 64'h0fc0_0c93_0fb0_0d13;
  prog_tab[3][3] = 64'hff9f_f06f_0fa0_0d93;
  stall_pct_tab[3] = 40;
  n_dep_tab[3]     = 16;
endtask

`endif

// File: testbench/tb_fetch_top.sv
// front end testbench
`timescale 1ns/10ps

module tb_fetch_top;

  import cpu_cfg_pkg::*;

  `include "tb_fetch_table.svh"

  localparam int DEP_TIMEOUT = 50;

  logic       i_clk;
  logic       i_rst;
  logic       i_imem_we;
  sram_addr_t i_imem_waddr;
  sram_data_t i_imem_wdata;
  logic       i_es_allowin;
  logic       o_ds_valid;
  pc_t        o_ds_pc;
  inst_t      o_ds_inst;
  logic       o_ds_is_jal;

  integer seed = 32'hd540_67c1;
  int     err_count = 0;
  int     n_checks = 0;
  int     rows_run = 0;
  bit     timed_out = 0;

  fetch_top u_dut (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_imem_we    (i_imem_we),
    .i_imem_waddr (i_imem_waddr),
    .i_imem_wdata (i_imem_wdata),
    .i_es_allowin (i_es_allowin),
    .o_ds_valid   (o_ds_valid),
    .o_ds_pc      (o_ds_pc),
    .o_ds_inst    (o_ds_inst),
    .o_ds_is_jal  (o_ds_is_jal)
  );

  // 40 ns period
  always #20 i_clk = ~i_clk;

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    n_checks++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    n_checks++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // execute ready unless the draw falls under the stall percentage
  function automatic logic draw_allowin(input int pct);
    int r;
    r = $unsigned($random(seed)) % 100;
    return (r >= pct);
  endfunction

  // pc[2] clear picks the upper half of the word
  function automatic inst_t model_inst(input int row, input pc_t pc);
    sram_data_t word;
    word = prog_tab[row][pc[4:3]];
    return pc[2] ? word[31:0] : word[63:32];
  endfunction

  // J-type offset scattered over inst[31:12]
  function automatic pc_t jump_dest(input pc_t pc, input inst_t inst);
    logic [20:0] imm;
    longint      off;
    imm        = '0;
    imm[20]    = inst[31];
    imm[19:12] = inst[19:12];
    imm[11]    = inst[20];
    imm[10:1]  = inst[30:21];
    // 21-bit two's complement
    off = longint'(imm);
    if (imm[20]) begin
      off = off - (longint'(1) << 21);
    end
    return pc + pc_t'(off);
  endfunction

  // one cycle per pass with outputs sampled at the falling edge
  task automatic wait_departure(input int pct, output bit seen);
    int cyc;
    seen = 1'b0;
    cyc = 0;
    while (!seen && cyc < DEP_TIMEOUT) begin
      @(posedge i_clk);
      #2;
      i_es_allowin = draw_allowin(pct);
      @(negedge i_clk);
      if (o_ds_valid && i_es_allowin) begin
        seen = 1'b1;
      end
      cyc++;
    end
  endtask

  task automatic run_row(input int row);
    pc_t   dep_pc;
    pc_t   fs_pc_m;
    pc_t   next_pc;
    inst_t exp_inst;
    logic  exp_jal;
    bit    seen;
    int    n;
    int    err_before;
    err_before = err_count;
    n = 0;
    // reset for 4 cycles while the loader fills the row
    for (int k = 0; k < ROW_WORDS; k++) begin
      @(posedge i_clk);
      #2;
      i_rst        = 1'b1;
      i_es_allowin = 1'b0;
      i_imem_we    = 1'b1;
      i_imem_waddr = sram_addr_t'(k);
      i_imem_wdata = prog_tab[row][k];
    end
    @(posedge i_clk);
    #2;
    i_rst     = 1'b0;
    i_imem_we = 1'b0;
    check_flag("o_ds_valid", o_ds_valid, 1'b0);
    // model holds the next to depart and the one behind it in fetch
    dep_pc  = BOOT_PC;
    fs_pc_m = BOOT_PC + 64'd4;
    while (n < n_dep_tab[row] && !timed_out) begin
      wait_departure(stall_pct_tab[row], seen);
      if (!seen) begin
        $display("timeout: row %0d saw no departure within %0d cycles", row, DEP_TIMEOUT);
        timed_out = 1'b1;
      end else begin
        exp_inst = model_inst(row, dep_pc);
        // jal major opcode
        exp_jal  = (exp_inst[6:0] == 7'b110_1111);
        check_pc("o_ds_pc", o_ds_pc, dep_pc);
        check_inst("o_ds_inst", o_ds_inst, exp_inst);
        check_flag("o_ds_is_jal", o_ds_is_jal, exp_jal);
        // fetch already holds the delay slot so the jump only bends what follows it
        next_pc = exp_jal ? jump_dest(dep_pc, exp_inst) : fs_pc_m + 64'd4;
        dep_pc  = fs_pc_m;
        fs_pc_m = next_pc;
        n++;
      end
    end
    rows_run++;
    $display("row %0d: %0d departures checked, %0d errors", row, n, err_count - err_before);
  endtask

  initial begin
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    i_imem_we    = 1'b0;
    i_imem_waddr = '0;
    i_imem_wdata = '0;
    i_es_allowin = 1'b0;
    fill_table();
    for (int row = 0; row < NUM_ROWS; row++) begin
      if (!timed_out) begin
        run_row(row);
      end
    end
    $display("rows %0d, checks %0d, errors %0d", rows_run, n_checks, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+testbench
verilog/cpu_cfg_pkg.sv
verilog/rv_isa_pkg.sv
verilog/inst_sram.sv
verilog/if_stage.sv
verilog/ds_pipe_reg.sv
verilog/id_branch_unit.sv
verilog/fetch_top.sv
testbench/tb_fetch_top.sv
